//--- logic/axil_pkg.sv
// AXI4-Lite register map of the divide unit
// offsets, address width, status bits and response codes
package axil_pkg;

    localparam int axil_addr_w = 8;

    localparam logic [axil_addr_w-1:0] reg_a      = 8'h00;  // dividend, r/w
    localparam logic [axil_addr_w-1:0] reg_b      = 8'h04;  // divisor, r/w
    localparam logic [axil_addr_w-1:0] reg_ctrl   = 8'h08;  // op code, write starts
    localparam logic [axil_addr_w-1:0] reg_status = 8'h0C;  // read only
    localparam logic [axil_addr_w-1:0] reg_quot   = 8'h10;  // read only
    localparam logic [axil_addr_w-1:0] reg_rem    = 8'h14;  // read only

    localparam int stat_busy = 0;
    localparam int stat_done = 1;
    localparam int stat_dbz  = 2;  // last division had a zero divisor

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

endpackage

//--- logic/clz.sv
// count leading zeros of one data word
// binary search over halves, so depth is log2 of the width
// all-zero input reads as all ones
`timescale 1ns/1ns

module clz (
    input  div_pkg::word_t clz_input,
    output div_pkg::clz_t  clz
);

    localparam int width  = $bits(div_pkg::word_t);
    localparam int levels = $bits(div_pkg::clz_t);

    always_comb begin
        logic [width-1:0] v;  // window being searched, kept left aligned
        v   = clz_input;
        clz = '0;
        // widest half first, each level decides one count bit
        for (int i = levels - 1; i >= 0; i--) begin
            if ((v >> (width - (1 << i))) == '0) begin  // top 2^i bits clear
                clz[i] = 1'b1;
                v      = v << (1 << i);  // move next window to the top
            end
        end
    end

endmodule

//--- logic/div_axil_regs.sv
// AXI4-Lite slave register block of the divide unit
// operand registers with byte strobes, ctrl write starts a division,
// status reports busy, done and divide by zero, results read only
// ctrl reads back the result of the op that was started
`timescale 1ns/1ns

module div_axil_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [axil_pkg::axil_addr_w-1:0] awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  div_pkg::word_t                   wdata,
    input  logic [div_pkg::data_w/8-1:0]     wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output axil_pkg::resp_t                  bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [axil_pkg::axil_addr_w-1:0] araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output div_pkg::word_t                   rdata,
    output axil_pkg::resp_t                  rresp,
    output logic                             rvalid,
    input  logic                             rready,
    output logic                             start,
    output div_pkg::div_op_t                 op,
    output div_pkg::word_t                   operand_a,
    output div_pkg::word_t                   operand_b,
    input  div_pkg::word_t                   quot,
    input  div_pkg::word_t                   rem,
    input  div_pkg::word_t                   result,
    input  logic                             done,
    input  logic                             dbz
);
    import div_pkg::*;
    import axil_pkg::*;

    logic  wr_ready;   // shared aw/w ready, one cycle wide
    logic  wr_hs;
    logic  wr_ok;      // write lands on a writable register
    logic  rd_hs;
    logic  busy;
    logic  done_flag;  // sticky until the next start
    logic  dbz_flag;
    word_t status_word;

    function automatic word_t apply_strb(word_t cur, word_t data,
                                         logic [data_w/8-1:0] strb);
        word_t res;
        res = cur;
        for (int i = 0; i < data_w / 8; i++) begin
            if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    assign awready = wr_ready;
    assign wready  = wr_ready;
    assign wr_hs   = awvalid && wvalid && wr_ready;
    assign arready = !rvalid;  // held rvalid stalls the read channel only
    assign rd_hs   = arvalid && arready;

    // operands and ctrl are locked while a division runs
    always_comb begin
        case (awaddr)
            reg_a, reg_b, reg_ctrl: wr_ok = !busy;
            default:                wr_ok = 1'b0;
        endcase
    end

    always_comb begin
        status_word            = '0;
        status_word[stat_busy] = busy;
        status_word[stat_done] = done_flag;
        status_word[stat_dbz]  = dbz_flag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready  <= 1'b0;
            bvalid    <= 1'b0;
            start     <= 1'b0;
            op        <= op_div;
            busy      <= 1'b0;
            done_flag <= 1'b0;
            dbz_flag  <= 1'b0;
        end else begin
            wr_ready <= awvalid && wvalid && !bvalid && !wr_ready;
            start    <= 1'b0;
            if (bvalid && bready) bvalid <= 1'b0;
            if (done) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
                dbz_flag  <= dbz;
            end
            if (wr_hs) begin
                bvalid <= 1'b1;
                if (wr_ok && (awaddr == reg_ctrl)) begin
                    op        <= div_op_t'(wdata[1:0]);
                    start     <= 1'b1;
                    busy      <= 1'b1;
                    done_flag <= 1'b0;
                    dbz_flag  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= wr_ok ? resp_okay : resp_slverr;
            if (wr_ok && (awaddr == reg_a)) operand_a <= apply_strb(operand_a, wdata, wstrb);
            if (wr_ok && (awaddr == reg_b)) operand_b <= apply_strb(operand_b, wdata, wstrb);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rresp <= resp_okay;
            case (araddr)
                reg_a:      rdata <= operand_a;
                reg_b:      rdata <= operand_b;
                reg_ctrl:   rdata <= result;
                reg_status: rdata <= status_word;
                reg_quot:   rdata <= quot;
                reg_rem:    rdata <= rem;
                default: begin
                    rdata <= '0;
                    rresp <= resp_slverr;  // unmapped offset
                end
            endcase
        end
    end

endmodule

//--- logic/div_pkg.sv
// divider package
// data width, word and count types, and operation codes
// for the integer divide unit
package div_pkg;

    localparam int data_w = 32;              // operand and result width
    localparam int clz_w  = $clog2(data_w);  // width of a leading-zero count

    typedef logic [data_w-1:0] word_t;  // one operand or result
    typedef logic [clz_w-1:0]  clz_t;   // one leading-zero count

    // low two bits of the RISC-V funct3 for the M-extension divides
    typedef enum logic [1:0] {
        op_div  = 2'b00,  // signed quotient
        op_divu = 2'b01,  // unsigned quotient
        op_rem  = 2'b10,  // signed remainder
        op_remu = 2'b11   // unsigned remainder
    } div_op_t;

endpackage

//--- logic/div_quick_clz.sv
// unsigned iterative divider, variable latency
// each step aligns the divisor under the remainder's leading one
// using leading-zero counts and retires one quotient bit per step,
// skipping all the zero bits in between
`timescale 1ns/1ns

module div_quick_clz (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           ack,
    input  div_pkg::word_t a,
    input  div_pkg::word_t b,
    output div_pkg::word_t q,
    output div_pkg::word_t r,
    output logic           complete,
    output logic           b_is_zero
);
    import div_pkg::*;

    logic            first_cycle;   // loads a and b
    logic            running;
    logic            terminate;     // remainder below divisor
    word_t           a_r;
    word_t           b_r;
    word_t           shifted_b;     // divisor with its leading one at the msb
    clz_t            r_clz;
    clz_t            b_clz;
    clz_t            b_clz_r;
    clz_t            clz_delta;
    logic [data_w:0] diff1;         // extra msb is the borrow
    word_t           diff2;
    word_t           b1;
    word_t           b2;
    word_t           q_bit1;
    word_t           q_bit2;
    word_t           new_r;
    word_t           new_q;

    clz clz_r_i (.clz_input(r), .clz(r_clz));
    clz clz_b_i (.clz_input(b), .clz(b_clz));

    // operands sampled every cycle, stable while busy
    always_ff @(posedge clk) begin
        a_r       <= a;
        b_r       <= b;
        b_clz_r   <= b_clz;
        shifted_b <= b_r << b_clz_r;  // first valid on the second cycle
    end

    assign clz_delta = b_clz_r - r_clz;  // quotient bit weight of this step

    always_comb begin
        q_bit1            = '0;
        q_bit1[clz_delta] = 1'b1;
    end
    assign q_bit2 = q_bit1 >> 1;

    assign b1    = shifted_b >> r_clz;            // aligned to r's leading one
    assign diff1 = {1'b0, r} - {1'b0, b1};
    assign b2    = b1 >> 1;                       // fallback when b1 is too big
    assign diff2 = r - b2;

    assign new_r = diff1[data_w] ? diff2 : diff1[data_w-1:0];
    assign new_q = q | (diff1[data_w] ? q_bit2 : q_bit1);

    // count is all ones for both zero and one, bit 0 tells them apart
    assign b_is_zero = (b_clz_r == '1) && !b_r[0];
    assign terminate = (r < b_r);

    always_ff @(posedge clk) begin
        if (rst) begin
            first_cycle <= 1'b0;
            running     <= 1'b0;
            complete    <= 1'b0;
        end else begin
            first_cycle <= start;
            if (first_cycle && !b_is_zero) begin
                running <= 1'b1;
            end else if (running && terminate) begin
                running <= 1'b0;
            end
            if (ack) begin
                complete <= 1'b0;
            end else if ((running && terminate) || (first_cycle && b_is_zero)) begin
                complete <= 1'b1;  // zero divisor finishes on the first cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (first_cycle) begin
            q <= b_is_zero ? '1 : '0;
            r <= a_r;
        end else if (running && !terminate) begin
            q <= new_q;
            r <= new_r;
        end
    end

endmodule

//--- logic/div_result_fixup.sv
// result fixup after the unsigned core
// restores signs, applies the zero-divisor rule and latches
// quotient, remainder and the op's selected result
`timescale 1ns/1ns

module div_result_fixup (
    input  logic           clk,
    input  logic           rst,
    input  logic           complete,
    input  logic           b_is_zero,
    input  div_pkg::word_t q_raw,
    input  div_pkg::word_t r_raw,
    input  logic           neg_q,
    input  logic           neg_r,
    input  logic           sel_rem,
    input  div_pkg::word_t a_orig,
    output div_pkg::word_t quot,
    output div_pkg::word_t rem,
    output div_pkg::word_t result,  // quot or rem, picked by the op
    output logic           done,
    output logic           dbz,
    output logic           ack
);
    import div_pkg::*;

    logic  take;  // first cycle of complete
    word_t quot_v;
    word_t rem_v;

    assign take = complete && !ack;

    // zero divisor: quotient all ones, remainder is the dividend
    assign quot_v = b_is_zero ? '1 : (neg_q ? (~q_raw + word_t'(1)) : q_raw);
    assign rem_v  = b_is_zero ? a_orig : (neg_r ? (~r_raw + word_t'(1)) : r_raw);

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
            ack  <= 1'b0;
            dbz  <= 1'b0;
        end else begin
            done <= take;  // one-cycle pulses, ack drops complete next edge
            ack  <= take;
            if (take) dbz <= b_is_zero;  // held until the next result
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            quot   <= quot_v;
            rem    <= rem_v;
            result <= sel_rem ? rem_v : quot_v;
        end
    end

endmodule

//--- logic/div_sign_ctrl.sv
// sign handling in front of the unsigned core
// forms operand magnitudes for signed ops and records
// the result signs and op kind at start
`timescale 1ns/1ns

module div_sign_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  div_pkg::div_op_t op,
    input  div_pkg::word_t   operand_a,
    input  div_pkg::word_t   operand_b,
    output div_pkg::word_t   mag_a,
    output div_pkg::word_t   mag_b,
    output div_pkg::word_t   a_orig,   // dividend as written, for zero divisor
    output logic             neg_q,
    output logic             neg_r,
    output logic             sel_rem
);
    import div_pkg::*;

    logic is_signed;
    logic sign_a;
    logic sign_b;

    assign is_signed = (op == op_div) || (op == op_rem);
    assign sign_a    = is_signed && operand_a[data_w-1];
    assign sign_b    = is_signed && operand_b[data_w-1];

    // most negative value maps onto itself, which is its unsigned magnitude
    assign mag_a = sign_a ? (~operand_a + word_t'(1)) : operand_a;
    assign mag_b = sign_b ? (~operand_b + word_t'(1)) : operand_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            neg_q   <= 1'b0;
            neg_r   <= 1'b0;
            sel_rem <= 1'b0;
        end else if (start) begin
            neg_q   <= sign_a ^ sign_b;  // quotient sign
            neg_r   <= sign_a;           // remainder follows the dividend
            sel_rem <= (op == op_rem) || (op == op_remu);
        end
    end

    always_ff @(posedge clk) begin
        if (start) a_orig <= operand_a;
    end

endmodule

//--- logic/div_unit_top.sv
// memory-mapped integer divide unit
// register block feeds the sign controller and the unsigned core
// side by side, the fixup stage merges them into the results
`timescale 1ns/1ns

module div_unit_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [axil_pkg::axil_addr_w-1:0] awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  div_pkg::word_t                   wdata,
    input  logic [div_pkg::data_w/8-1:0]     wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output axil_pkg::resp_t                  bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [axil_pkg::axil_addr_w-1:0] araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output div_pkg::word_t                   rdata,
    output axil_pkg::resp_t                  rresp,
    output logic                             rvalid,
    input  logic                             rready
);
    import div_pkg::*;

    logic    start;
    div_op_t op;
    word_t   operand_a;
    word_t   operand_b;
    word_t   mag_a;
    word_t   mag_b;
    word_t   a_orig;
    logic    neg_q;
    logic    neg_r;
    logic    sel_rem;
    word_t   q_raw;
    word_t   r_raw;
    logic    complete;
    logic    b_is_zero;
    logic    ack;
    word_t   quot;
    word_t   rem;
    word_t   result;
    logic    done;
    logic    dbz;

    div_axil_regs div_axil_regs_i (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .start     (start),
        .op        (op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .quot      (quot),
        .rem       (rem),
        .result    (result),
        .done      (done),
        .dbz       (dbz)
    );

    div_sign_ctrl div_sign_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op        (op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .mag_a     (mag_a),
        .mag_b     (mag_b),
        .a_orig    (a_orig),
        .neg_q     (neg_q),
        .neg_r     (neg_r),
        .sel_rem   (sel_rem)
    );

    div_quick_clz div_quick_clz_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .ack       (ack),
        .a         (mag_a),
        .b         (mag_b),
        .q         (q_raw),
        .r         (r_raw),
        .complete  (complete),
        .b_is_zero (b_is_zero)
    );

    div_result_fixup div_result_fixup_i (
        .clk       (clk),
        .rst       (rst),
        .complete  (complete),
        .b_is_zero (b_is_zero),
        .q_raw     (q_raw),
        .r_raw     (r_raw),
        .neg_q     (neg_q),
        .neg_r     (neg_r),
        .sel_rem   (sel_rem),
        .a_orig    (a_orig),
        .quot      (quot),
        .rem       (rem),
        .result    (result),
        .done      (done),
        .dbz       (dbz),
        .ack       (ack)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the divide unit testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f sources.f --top-module div_tb -o div_sim \
    && ./obj_dir/div_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation reported errors"; exit 1; }
echo "simulation clean"
exit 0

//--- sources.f
+incdir+testbench
logic/div_pkg.sv
logic/axil_pkg.sv
logic/clz.sv
logic/div_quick_clz.sv
logic/div_sign_ctrl.sv
logic/div_result_fixup.sv
logic/div_axil_regs.sv
logic/div_unit_top.sv
testbench/div_tb.sv

//--- testbench/div_tb_tasks.svh
// AXI4-Lite master tasks and typed compare tasks for the divider testbench
// every task starts and ends 2 ns after a rising clock edge

task automatic next_cycle();
    @(posedge clk);
    #2;  // drive and sample point once DUT outputs have settled
endtask

task automatic axil_write(input logic [axil_addr_w-1:0] addr, input word_t data,
                          input logic [data_w/8-1:0] strb, output resp_t resp);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (!(awready && wready)) next_cycle();  // both readies show up a cycle before the handshake edge
    next_cycle();                               // aw and w accepted here
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) next_cycle();
    resp = bresp;
    next_cycle();  // response taken so bvalid drops
    bready = 1'b0;
endtask

task automatic axil_read(input logic [axil_addr_w-1:0] addr, output word_t data,
                         output resp_t resp);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (!arready) next_cycle();  // arready low only while rvalid is held
    next_cycle();                   // address accepted
    arvalid = 1'b0;
    while (!rvalid) next_cycle();
    data = rdata;
    resp = rresp;
    next_cycle();
    rready = 1'b0;
endtask

task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                 $time, name, expected, actual);
    end
endtask

task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
                 $time, name, expected, actual);
    end
endtask

//--- testbench/div_tb.sv
// testbench for the memory-mapped divide unit
// drives divides over AXI4-Lite with random operands from a fixed seed
// and checks results and status against a RISC-V reference model
`timescale 1ns/1ns

module div_tb;
    import div_pkg::*;
    import axil_pkg::*;

    localparam int    clk_period  = 40;
    localparam int    max_divs    = 200;                  // upper bound on divisions run
    localparam int    div_cycles  = 80;                   // AXI traffic plus worst core latency
    localparam int    cycle_limit = max_divs * div_cycles;
    localparam word_t min_neg     = 32'h8000_0000;        // most negative value

    logic                   clk;
    logic                   rst;
    logic [axil_addr_w-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    word_t                  wdata;
    logic [data_w/8-1:0]    wstrb;
    logic                   wvalid;
    logic                   wready;
    resp_t                  bresp;
    logic                   bvalid;
    logic                   bready;
    logic [axil_addr_w-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    word_t                  rdata;
    resp_t                  rresp;
    logic                   rvalid;
    logic                   rready;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int seed   = 91;

    div_unit_top div_unit_top_i (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    `include "div_tb_tasks.svh"

    // RISC-V M-extension quotient
    function automatic word_t riscv_quot(div_op_t op, word_t a, word_t b);
        logic sgn;
        sgn = (op == op_div) || (op == op_rem);
        if (b == '0) return '1;                    // divide by zero
        if (!sgn) return a / b;
        if (a == min_neg && b == '1) return a;     // signed overflow
        return word_t'($signed(a) / $signed(b));   // truncates toward zero
    endfunction

    // RISC-V M-extension remainder, sign follows the dividend
    function automatic word_t riscv_rem(div_op_t op, word_t a, word_t b);
        logic sgn;
        sgn = (op == op_div) || (op == op_rem);
        if (b == '0) return a;
        if (!sgn) return a % b;
        if (a == min_neg && b == '1) return '0;
        return word_t'($signed(a) % $signed(b));
    endfunction

    task automatic start_division(div_op_t op, word_t a, word_t b);
        resp_t resp;
        axil_write(reg_a, a, 4'hf, resp);
        check_resp("bresp reg_a", resp_okay, resp);
        axil_write(reg_b, b, 4'hf, resp);
        check_resp("bresp reg_b", resp_okay, resp);
        axil_write(reg_ctrl, {30'b0, op}, 4'hf, resp);  // this write starts the core
        check_resp("bresp reg_ctrl", resp_okay, resp);
    endtask

    task automatic finish_division(div_op_t op, word_t a, word_t b);
        word_t data;
        word_t exp_q;
        word_t exp_r;
        word_t exp_stat;
        resp_t resp;
        exp_q               = riscv_quot(op, a, b);
        exp_r               = riscv_rem(op, a, b);
        exp_stat            = '0;
        exp_stat[stat_done] = 1'b1;
        exp_stat[stat_dbz]  = (b == '0);
        data                = '0;
        while (!data[stat_done]) axil_read(reg_status, data, resp);  // poll until done
        check_word("status", exp_stat, data);
        axil_read(reg_quot, data, resp);
        check_word("quot", exp_q, data);
        axil_read(reg_rem, data, resp);
        check_word("rem", exp_r, data);
        axil_read(reg_ctrl, data, resp);  // result picked by the op
        check_word("result", (op == op_rem || op == op_remu) ? exp_r : exp_q, data);
        check_resp("rresp", resp_okay, resp);
    endtask

    task automatic run_division(div_op_t op, word_t a, word_t b);
        start_division(op, a, b);
        finish_division(op, a, b);
    endtask

    task automatic register_tests();
        word_t data;
        resp_t resp;
        axil_write(reg_a, 32'h1122_3344, 4'hf, resp);
        check_resp("bresp reg_a", resp_okay, resp);
        axil_read(reg_a, data, resp);
        check_word("operand_a", 32'h1122_3344, data);
        axil_write(reg_a, 32'haabb_ccdd, 4'b0101, resp);  // bytes 0 and 2 only
        axil_read(reg_a, data, resp);
        check_word("operand_a strobed", 32'h11bb_33dd, data);
        axil_write(reg_b, 32'h5566_7788, 4'hf, resp);
        axil_read(reg_b, data, resp);
        check_word("operand_b", 32'h5566_7788, data);
        axil_write(reg_b, 32'hcafe_f00d, 4'b1010, resp);  // bytes 1 and 3 only
        axil_read(reg_b, data, resp);
        check_word("operand_b strobed", 32'hca66_f088, data);
        axil_write(reg_status, 32'h0000_0007, 4'hf, resp);  // read-only offset
        check_resp("bresp reg_status", resp_slverr, resp);
    endtask

    task automatic unsigned_tests();
        word_t   a;
        word_t   b;
        word_t   rnd;
        div_op_t op;
        for (int i = 0; i < 120; i++) begin
            a   = $random(seed);
            b   = $random(seed);
            rnd = $random(seed);
            op  = rnd[0] ? op_remu : op_divu;
            case (rnd[2:1])
                2'd0:    b = b & 32'h0000_000f;  // tiny divisor, long quotient
                2'd1:    b = b >> rnd[7:3];      // random size
                default: ;
            endcase
            run_division(op, a, b);
        end
    endtask

    task automatic signed_tests();
        word_t   a;
        word_t   b;
        word_t   rnd;
        div_op_t op;
        for (int i = 0; i < 60; i++) begin
            a   = $random(seed) & 32'h7fff_ffff;  // magnitudes first
            b   = $random(seed) & 32'h7fff_ffff;
            rnd = $random(seed);
            op  = rnd[0] ? op_rem : op_div;
            if (rnd[3]) b = b & 32'h0000_00ff;
            if (i % 10 == 0) a = '0;              // zero dividend
            if (i[0]) a = ~a + 32'd1;             // sign combo cycles every 4
            if (i[1]) b = ~b + 32'd1;
            run_division(op, a, b);
        end
    endtask

    task automatic corner_tests();
        // zero divisor under every op
        run_division(op_div, 32'hdead_beef, '0);
        run_division(op_divu, 32'h1234_5678, '0);
        run_division(op_rem, 32'hfedc_ba98, '0);
        run_division(op_remu, 32'h0000_0001, '0);
        run_division(op_div, min_neg, '1);   // overflow keeps the dividend
        run_division(op_rem, min_neg, '1);
        run_division(op_divu, min_neg, '1);  // plain unsigned, quotient zero
    endtask

    task automatic busy_tests();
        word_t data;
        resp_t resp;
        start_division(op_divu, 32'hffff_ffff, 32'd1);  // every quotient bit set, slowest case
        axil_write(reg_ctrl, {30'b0, op_remu}, 4'hf, resp);
        check_resp("bresp reg_ctrl busy", resp_slverr, resp);
        axil_write(reg_a, 32'd5, 4'hf, resp);
        check_resp("bresp reg_a busy", resp_slverr, resp);
        finish_division(op_divu, 32'hffff_ffff, 32'd1);
        axil_read(reg_a, data, resp);
        check_word("operand_a kept", 32'hffff_ffff, data);
        axil_read(8'h18, data, resp);  // first offset past the map
        check_resp("rresp unmapped", resp_slverr, resp);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // run length guard
    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("run timed out after %0d cycles without finishing the tests", cycles);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (3) next_cycle();
        rst = 1'b0;
        next_cycle();
        register_tests();
        unsigned_tests();
        signed_tests();
        corner_tests();
        busy_tests();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
